// ==== decode_stage.f ====
source/decode_pkg.sv
source/fetch_hold.sv
source/op_decoder.sv
source/imm_gen.sv
source/hazard_unit.sv
source/issue_stage.sv
source/decode_stage.sv
verif/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_decode_stage
FILELIST  = decode_stage.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// ==== verif/tb_decode_stage.sv ====
////////////////////////////////////////
// Testbench for the decode stage
// Clock, stimulus, rule-based model, assertions
////////////////////////////////////////

`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam int PERIOD         = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int N_RANDOM       = 60;
    localparam int N_HAZARD       = 4;
    localparam int N_ILLEGAL      = 12;
    localparam int N_STALL        = 80;
    localparam int RUN_CYCLES     = RESET_CYCLES + N_RANDOM + N_HAZARD * 4 + 8
                                    + N_ILLEGAL + 4 + N_STALL + 4;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;
    localparam logic [XLEN-1:0] BANK_MUL = 32'h01010101;

    logic                  clk;
    logic                  reset;
    logic                  stall_i;
    decode_req_t           req_i;
    logic [XLEN-1:0]       rs1_data_i;
    logic [XLEN-1:0]       rs2_data_i;
    logic [REG_ADDR_W-1:0] rs1_addr_o;
    logic [REG_ADDR_W-1:0] rs2_addr_o;
    logic [REG_ADDR_W-1:0] rd_o;
    logic                  hazard_o;
    issue_t                issue_o;
    int                    error_count;
    logic [TAG_W-1:0]      tag_cnt;

    decode_stage decode_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .req_i      (req_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_o       (rd_o),
        .hazard_o   (hazard_o),
        .issue_o    (issue_o)
    );

    // Register bank answers address a with a * 0x01010101
    assign rs1_data_i = BANK_MUL * rs1_addr_o;
    assign rs2_data_i = BANK_MUL * rs2_addr_o;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference decode rules
    ////////////////////////////////////////

    function automatic format_e format_of(input logic [6:0] opc);
        case (opc)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return I_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic op_e operation_of(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OPC_LUI:    return LUI;
            OPC_AUIPC:  return ADD;
            OPC_JAL:    return JAL;
            OPC_JALR:   return (f3 == 3'd0) ? JALR : INVALID;
            OPC_BRANCH: begin
                op_e br[8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
                return br[f3];
            end
            OPC_LOAD: begin
                op_e ld[8] = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
                return ld[f3];
            end
            OPC_STORE:  return (f3 == 3'd0) ? SB : (f3 == 3'd1) ? SH
                             : (f3 == 3'd2) ? SW : INVALID;
            OPC_OP_IMM, OPC_OP: begin
                op_e alu[8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
                logic shift;
                logic alt_ok;
                shift  = (f3 == 3'd1) || (f3 == 3'd5);
                // SUB and SRA take the alternate funct7
                alt_ok = (f3 == 3'd5) || (f3 == 3'd0 && w[6:0] == OPC_OP);
                if (w[6:0] == OPC_OP_IMM && !shift) return alu[f3];
                if (f7 == 7'b0000000) return alu[f3];
                if (f7 == 7'b0100000 && alt_ok) return (f3 == 3'd0) ? SUB : SRA;
                return INVALID;
            end
            default:    return INVALID;
        endcase
    endfunction

    function automatic logic [31:0] immediate_of(input logic [31:0] w, input format_e f);
        case (f)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Expected model of the stage
    ////////////////////////////////////////

    logic [31:0]           m_held;
    logic                  m_replay;
    logic [REG_ADDR_W-1:0] m_lock;
    logic [REG_ADDR_W-1:0] m_rd;
    issue_t                m_issue;
    logic [31:0]           m_work;
    format_e               m_fmt;
    logic                  m_haz;
    issue_t                m_next;

    always_comb begin
        logic [31:0] imm;
        logic [31:0] src1;
        logic [31:0] src2;
        m_work = m_replay ? m_held : req_i.instr;
        m_fmt  = format_of(m_work[6:0]);
        imm    = immediate_of(m_work, m_fmt);
        src1   = BANK_MUL * m_work[19:15];
        src2   = BANK_MUL * m_work[24:20];
        m_haz  = (m_fmt != U_TYPE && m_fmt != J_TYPE && m_work[19:15] != 5'd0
                  && m_work[19:15] == m_lock)
              || ((m_fmt == R_TYPE || m_fmt == S_TYPE || m_fmt == B_TYPE)
                  && m_work[24:20] != 5'd0 && m_work[24:20] == m_lock);
        m_next            = '0;
        m_next.op         = operation_of(m_work);
        m_next.first_op   = (m_fmt == U_TYPE || m_fmt == J_TYPE) ? req_i.pc : src1;
        m_next.second_op  = (m_fmt == R_TYPE || m_fmt == B_TYPE) ? src2 : imm;
        m_next.third_op   = (m_fmt == S_TYPE) ? src2 : imm;
        m_next.pc         = req_i.pc;
        m_next.instr      = m_work;
        m_next.tag        = req_i.tag;
        m_next.illegal    = (m_next.op == INVALID);
        m_next.misaligned = (req_i.pc[1:0] != 2'b00);
    end

    always_ff @(posedge clk) begin
        m_held <= m_work;
        if (reset) begin
            m_replay <= 1'b0;
            m_lock   <= '0;
            m_rd     <= '0;
            m_issue  <= '0;
        end else begin
            m_replay <= m_haz;
            if (!stall_i) begin
                m_lock <= m_haz ? 5'd0 : m_work[11:7];
                m_rd   <= m_lock;
            end
            if (m_haz) begin
                m_issue     <= '0;
                m_issue.tag <= req_i.tag;
            end else if (!stall_i) begin
                m_issue <= m_next;
            end
        end
    end

    check_issue: assert property (@(posedge clk) disable iff (reset) issue_o == m_issue)
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: issue_o %h, expected %h", $time, issue_o, m_issue);
        end

    check_hazard: assert property (@(posedge clk) disable iff (reset) hazard_o == m_haz)
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: hazard_o %b, expected %b", $time, hazard_o, m_haz);
        end

    check_rd: assert property (@(posedge clk) disable iff (reset) rd_o == m_rd)
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: rd_o %0d, expected %0d", $time, rd_o, m_rd);
        end

    check_addr: assert property (@(posedge clk) disable iff (reset)
        rs1_addr_o == m_work[19:15] && rs2_addr_o == m_work[24:20])
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: register read addresses differ", $time);
        end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] legal_instr(input int grp, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  opcs[9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                 OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
        w  = $urandom;
        f3 = w[14:12];
        case (grp)
            3: f3 = 3'd0;
            4: if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
            5: if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
            6: if (f3 > 3'd2) f3 = 3'd2;
            7: if (f3 == 3'd1 || f3 == 3'd5) w[31:25] = {1'b0, w[30] & f3[2], 5'b0};
            8: w[31:25] = {1'b0, w[30] & (f3 == 3'd0 || f3 == 3'd5), 5'b0};
            default: ;
        endcase
        w[6:0]   = opcs[grp];
        w[14:12] = f3;
        w[11:7]  = rd;
        w[19:15] = rs1;
        w[24:20] = rs2;
        return w;
    endfunction

    function automatic logic [31:0] aligned_pc();
        logic [31:0] pc;
        pc      = $urandom;
        pc[1:0] = 2'b00;
        return pc;
    endfunction

    task automatic apply(input logic [31:0] instr, input logic [31:0] pc, input logic stall);
        @(posedge clk);
        req_i.instr <= instr;
        req_i.pc    <= pc;
        req_i.tag   <= tag_cnt;
        stall_i     <= stall;
        tag_cnt     = tag_cnt + 1'b1;
    endtask

    function automatic logic [4:0] avoid(input logic [4:0] reg_no);
        logic [4:0] r;
        r = 5'($urandom);
        while (r == reg_no && r != 5'd0) r = 5'($urandom);
        return r;
    endfunction

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        logic [4:0]  prev_rd;
        logic [4:0]  rd;
        logic [31:0] w;
        logic [6:0]  opc;
        void'($urandom(32'h4dd05abc));
        error_count = 0;
        tag_cnt     = '0;
        reset       = 1'b1;
        stall_i     = 1'b0;
        req_i       = '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        assert (issue_o.op == NOP && issue_o == '0 && !hazard_o && rd_o == '0)
            else begin
                error_count = error_count + 1;
                $display("MISMATCH at %0t: state after reset is not a bubble", $time);
            end
        @(posedge clk);
        reset <= 1'b0;

        // Legal instructions where no source reads the previous rd
        prev_rd = 5'd0;
        for (int i = 0; i < N_RANDOM; i++) begin
            rd = 5'($urandom);
            apply(legal_instr($urandom_range(8, 0), rd, avoid(prev_rd), avoid(prev_rd)),
                  aligned_pc(), 1'b0);
            prev_rd = rd;
        end

        // Read-after-write pairs
        for (int i = 0; i < N_HAZARD; i++) begin
            rd = 5'($urandom_range(31, 1));
            apply(legal_instr(8, rd, avoid(rd), avoid(rd)), aligned_pc(), 1'b0);
            w = legal_instr(i % 2 == 0 ? 8 : 6, 5'd0, rd, avoid(rd));
            apply(w, aligned_pc(), 1'b0);
            apply(w, aligned_pc(), 1'b0);
            apply(legal_instr(0, 5'd0, 5'd0, 5'd0), aligned_pc(), 1'b0);
        end
        // x0 writer and a U-type reader
        apply(legal_instr(8, 5'd0, 5'd3, 5'd4), aligned_pc(), 1'b0);
        apply(legal_instr(8, 5'd1, 5'd0, 5'd0), aligned_pc(), 1'b0);
        apply(legal_instr(8, 5'd9, 5'd2, 5'd2), aligned_pc(), 1'b0);
        apply(legal_instr(0, 5'd1, 5'd9, 5'd9), aligned_pc(), 1'b0);
        apply(legal_instr(0, 5'd0, 5'd0, 5'd0), aligned_pc(), 1'b0);
        repeat (3) apply(legal_instr(0, 5'd0, 5'd0, 5'd0), aligned_pc(), 1'b0);

        // Undefined opcodes, SYSTEM, FENCE and misaligned pc
        apply({25'($urandom), 7'b1110011}, aligned_pc(), 1'b0);
        apply({25'($urandom), 7'b0001111}, aligned_pc(), 1'b0);
        for (int i = 0; i < N_ILLEGAL - 2; i++) begin
            opc = 7'($urandom);
            while (format_of(opc) != R_TYPE || opc == OPC_OP) opc = 7'($urandom);
            apply({25'($urandom), opc}, aligned_pc(), 1'b0);
        end
        for (int i = 1; i < 4; i++) begin
            apply(legal_instr(0, 5'd0, 5'd0, 5'd0), aligned_pc() | 32'(i), 1'b0);
        end
        apply(legal_instr(0, 5'd0, 5'd0, 5'd0), aligned_pc(), 1'b0);

        // Random stalls over mixed traffic
        for (int i = 0; i < N_STALL; i++) begin
            apply(legal_instr($urandom_range(8, 0), 5'($urandom), 5'($urandom), 5'($urandom)),
                  aligned_pc(), ($urandom_range(2, 0) == 0));
        end
        apply(legal_instr(0, 5'd0, 5'd0, 5'd0), aligned_pc(), 1'b0);
        repeat (3) @(posedge clk);
        // Let the last edge's assertions settle
        @(negedge clk);

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== source/decode_stage.sv ====
////////////////////////////////////////
// Decode stage top level
////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              stall_i,
    input  decode_pkg::decode_req_t           req_i,
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                              hazard_o,
    output decode_pkg::issue_t                issue_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] work_instr;
    logic [XLEN-1:0] imm;
    decoded_t        decoded;
    logic            hazard;

    fetch_hold fetch_hold_inst (
        .clk      (clk),
        .reset    (reset),
        .instr_i  (req_i.instr),
        .hazard_i (hazard),
        .instr_o  (work_instr)
    );

    op_decoder op_decoder_inst (
        .instr_i   (work_instr),
        .decoded_o (decoded)
    );

    imm_gen imm_gen_inst (
        .instr_i  (work_instr),
        .format_i (decoded.fmt),
        .imm_o    (imm)
    );

    hazard_unit hazard_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .stall_i   (stall_i),
        .decoded_i (decoded),
        .hazard_o  (hazard),
        .rd_o      (rd_o)
    );

    issue_stage issue_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .hazard_i   (hazard),
        .req_i      (req_i),
        .instr_i    (work_instr),
        .decoded_i  (decoded),
        .imm_i      (imm),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .issue_o    (issue_o)
    );

    // Register bank read addresses
    assign rs1_addr_o = decoded.rs1;
    assign rs2_addr_o = decoded.rs2;
    assign hazard_o   = hazard;

endmodule

// ==== source/issue_stage.sv ====
////////////////////////////////////////
// Operand select, exception flags
// Issue record register
////////////////////////////////////////

`timescale 1ns/1ps

module issue_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall_i,
    input  logic                        hazard_i,
    input  decode_pkg::decode_req_t     req_i,
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    input  decode_pkg::decoded_t        decoded_i,
    input  logic [decode_pkg::XLEN-1:0] imm_i,
    input  logic [decode_pkg::XLEN-1:0] rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0] rs2_data_i,
    output decode_pkg::issue_t          issue_o
);
    import decode_pkg::*;

    issue_t next_rec;
    issue_t bubble;

    ////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////

    always_comb begin
        next_rec = '0;
        case (decoded_i.fmt)
            U_TYPE, J_TYPE: begin
                next_rec.first_op  = req_i.pc;
                next_rec.second_op = imm_i;
                next_rec.third_op  = imm_i;
            end
            R_TYPE, B_TYPE: begin
                next_rec.first_op  = rs1_data_i;
                next_rec.second_op = rs2_data_i;
                next_rec.third_op  = imm_i;
            end
            S_TYPE: begin
                // Store data rides in the third operand
                next_rec.first_op  = rs1_data_i;
                next_rec.second_op = imm_i;
                next_rec.third_op  = rs2_data_i;
            end
            default: begin
                next_rec.first_op  = rs1_data_i;
                next_rec.second_op = imm_i;
                next_rec.third_op  = imm_i;
            end
        endcase
        next_rec.op         = decoded_i.op;
        next_rec.pc         = req_i.pc;
        next_rec.instr      = instr_i;
        next_rec.tag        = req_i.tag;
        next_rec.illegal    = (decoded_i.op == INVALID);
        next_rec.misaligned = (req_i.pc[1:0] != 2'b00);
    end

    // NOP with the current tag
    always_comb begin
        bubble     = '0;
        bubble.op  = NOP;
        bubble.tag = req_i.tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_o    <= '0;
            issue_o.op <= NOP;
        end else if (hazard_i) begin
            issue_o <= bubble;
        end else if (!stall_i) begin
            issue_o <= next_rec;
        end
    end

endmodule

// ==== source/hazard_unit.sv ====
////////////////////////////////////////
// Register lock queue and hazard check
////////////////////////////////////////

`timescale 1ns/1ps

module hazard_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              stall_i,
    input  decode_pkg::decoded_t              decoded_i,
    output logic                              hazard_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o
);
    import decode_pkg::*;

    logic [REG_ADDR_W-1:0] lock_reg;
    logic [REG_ADDR_W-1:0] target_reg;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  hazard_rs1;
    logic                  hazard_rs2;

    // A bubble locks nothing
    assign target_reg = hazard_o ? '0 : decoded_i.rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_reg <= '0;
            rd_o     <= '0;
        end else if (!stall_i) begin
            lock_reg <= target_reg;
            rd_o     <= lock_reg;
        end
    end

    ////////////////////////////////////////
    // Source usage by format
    ////////////////////////////////////////

    assign use_rs1 = decoded_i.fmt inside {R_TYPE, I_TYPE, S_TYPE, B_TYPE};
    assign use_rs2 = decoded_i.fmt inside {R_TYPE, S_TYPE, B_TYPE};

    // x0 never conflicts
    assign hazard_rs1 = use_rs1 && (decoded_i.rs1 != '0) && (decoded_i.rs1 == lock_reg);
    assign hazard_rs2 = use_rs2 && (decoded_i.rs2 != '0) && (decoded_i.rs2 == lock_reg);

    assign hazard_o = hazard_rs1 | hazard_rs2;

endmodule

// ==== source/imm_gen.sv ====
////////////////////////////////////////
// Immediate generator for all formats
////////////////////////////////////////

`timescale 1ns/1ps

module imm_gen (
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    input  decode_pkg::format_e         format_i,
    output logic [decode_pkg::XLEN-1:0] imm_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_s_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_u_type;
    logic [XLEN-1:0] imm_j_type;

    // Sign bit is always instr_i[31]
    assign imm_i_type = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s_type = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        case (format_i)
            I_TYPE:  imm_o = imm_i_type;
            S_TYPE:  imm_o = imm_s_type;
            B_TYPE:  imm_o = imm_b_type;
            U_TYPE:  imm_o = imm_u_type;
            J_TYPE:  imm_o = imm_j_type;
            // R-type carries no immediate
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== source/op_decoder.sv ====
////////////////////////////////////////
// Operation and format decoder
// Register field extraction
////////////////////////////////////////

`timescale 1ns/1ps

module op_decoder (
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    output decode_pkg::decoded_t        decoded_o
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op;
    format_e    fmt;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////
    // Operation
    ////////////////////////////////////////

    always_comb begin
        op = INVALID;
        case (opcode)
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = ADD;
            OPC_JAL:   op = JAL;
            OPC_JALR:  op = (funct3 == 3'b000) ? JALR : INVALID;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = LB;
                    3'b001:  op = LH;
                    3'b010:  op = LW;
                    3'b100:  op = LBU;
                    3'b101:  op = LHU;
                    default: op = INVALID;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op = SB;
                    3'b001:  op = SH;
                    3'b010:  op = SW;
                    default: op = INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                // funct7 only matters for shifts
                case (funct3)
                    3'b000: op = ADD;
                    3'b001: op = (funct7 == F7_BASE) ? SLL : INVALID;
                    3'b010: op = SLT;
                    3'b011: op = SLTU;
                    3'b100: op = XOR;
                    3'b101: begin
                        if (funct7 == F7_BASE) begin
                            op = SRL;
                        end else if (funct7 == F7_ALT) begin
                            op = SRA;
                        end
                    end
                    3'b110: op = OR;
                    default: op = AND;
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: op = ADD;
                    {F7_ALT,  3'b000}: op = SUB;
                    {F7_BASE, 3'b001}: op = SLL;
                    {F7_BASE, 3'b010}: op = SLT;
                    {F7_BASE, 3'b011}: op = SLTU;
                    {F7_BASE, 3'b100}: op = XOR;
                    {F7_BASE, 3'b101}: op = SRL;
                    {F7_ALT,  3'b101}: op = SRA;
                    {F7_BASE, 3'b110}: op = OR;
                    {F7_BASE, 3'b111}: op = AND;
                    default:           op = INVALID;
                endcase
            end
            default: op = INVALID;
        endcase
    end

    ////////////////////////////////////////
    // Format
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: fmt = I_TYPE;
            OPC_STORE:                      fmt = S_TYPE;
            OPC_BRANCH:                     fmt = B_TYPE;
            OPC_LUI, OPC_AUIPC:             fmt = U_TYPE;
            OPC_JAL:                        fmt = J_TYPE;
            default:                        fmt = R_TYPE;
        endcase
    end

    assign decoded_o.op  = op;
    assign decoded_o.fmt = fmt;
    assign decoded_o.rs1 = instr_i[19:15];
    assign decoded_o.rs2 = instr_i[24:20];
    assign decoded_o.rd  = instr_i[11:7];

endmodule

// ==== source/fetch_hold.sv ====
////////////////////////////////////////
// Instruction hold and replay after a hazard
////////////////////////////////////////

`timescale 1ns/1ps

module fetch_hold (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    input  logic                        hazard_i,
    output logic [decode_pkg::XLEN-1:0] instr_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] last_instr;
    logic            last_hazard;

    // Working instruction kept every cycle
    always_ff @(posedge clk) begin
        last_instr <= instr_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hazard <= 1'b0;
        end else begin
            last_hazard <= hazard_i;
        end
    end

    // Stalled instruction gets decoded again
    assign instr_o = last_hazard ? last_instr : instr_i;

endmodule

// ==== source/decode_pkg.sv ====
////////////////////////////////////////
// Shared definitions for the decode stage
// Widths, opcode and funct constants
// Operation and format enums, stage records
////////////////////////////////////////

package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;

    // Major opcodes of the kept RV32I groups
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct7 patterns for ALU ops
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [4:0] {
        NOP, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        LUI, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        INVALID
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    // Request from fetch
    typedef struct packed {
        logic [XLEN-1:0]  instr;
        logic [XLEN-1:0]  pc;
        logic [TAG_W-1:0] tag;
    } decode_req_t;

    typedef struct packed {
        op_e                   op;
        format_e               fmt;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
    } decoded_t;

    // Record handed to execute
    typedef struct packed {
        op_e              op;
        logic [XLEN-1:0]  first_op;
        logic [XLEN-1:0]  second_op;
        logic [XLEN-1:0]  third_op;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  instr;
        logic [TAG_W-1:0] tag;
        logic             illegal;
        logic             misaligned;
    } issue_t;

endpackage
